/* filelist.f */
+incdir+hw
hw/ppfifo_bank_pkg.sv
hw/ppfifo_data_pkg.sv
hw/ppfifo_bank_fill.sv
hw/ppfifo_bank_memory.sv
hw/ppfifo_read_arbiter.sv
hw/ppfifo_bank_drain.sv
hw/ppfifo.sv
tests/ppfifo_tb.sv

/* hw/ppfifo.sv */
//##########################################################################
// Ping-pong FIFO top: write stage, storage, arbiter and read stage
//##########################################################################

`timescale 1ns/1ps

`include "ppfifo_cfg.svh"

module ppfifo
  import ppfifo_bank_pkg::*, ppfifo_data_pkg::*;
(
  input  logic        write_clock,
  input  logic        reset,
  input  bank_mask_t  write_activate,
  input  logic        write_strobe,
  input  data_t       write_data,
  input  logic        read_activate,
  input  logic        read_strobe,
  output bank_mask_t  write_ready,
  output word_count_t write_fifo_size,
  output logic        starved,
  output logic        read_ready,
  output word_count_t read_count,
  output data_t       read_data,
  output logic        inactive
);

  // Fill to arbiter
  bank_mask_t      bank_full;
  bank_mask_t      bank_done;
  word_count_t     full_count0;
  word_count_t     full_count1;

  // Arbiter to drain and back
  logic            offer_valid;
  bank_sel_t       offer_bank;
  word_count_t     offer_count;
  logic            offer_taken;
  logic            bank_released;
  bank_sel_t       release_bank;

  // Storage ports
  logic            write_enable;
  memory_address_t write_address;
  memory_address_t read_address;
  data_t           memory_data;

  // Depth of one bank
  assign write_fifo_size = word_count_t'(1 << `PPFIFO_ADDRESS_WIDTH);

  ppfifo_bank_fill u_bank_fill (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_activate (write_activate),
    .write_strobe   (write_strobe),
    .bank_done      (bank_done),
    .write_ready    (write_ready),
    .bank_full      (bank_full),
    .full_count0    (full_count0),
    .full_count1    (full_count1),
    .write_enable   (write_enable),
    .write_address  (write_address),
    .inactive       (inactive)
  );

  ppfifo_bank_memory u_bank_memory (
    .write_clock   (write_clock),
    .write_enable  (write_enable),
    .write_address (write_address),
    .write_data    (write_data),
    .read_address  (read_address),
    .memory_data   (memory_data)
  );

  ppfifo_read_arbiter u_read_arbiter (
    .write_clock   (write_clock),
    .reset         (reset),
    .bank_full     (bank_full),
    .full_count0   (full_count0),
    .full_count1   (full_count1),
    .offer_taken   (offer_taken),
    .bank_released (bank_released),
    .release_bank  (release_bank),
    .bank_done     (bank_done),
    .offer_valid   (offer_valid),
    .offer_bank    (offer_bank),
    .offer_count   (offer_count)
  );

  ppfifo_bank_drain u_bank_drain (
    .write_clock   (write_clock),
    .reset         (reset),
    .offer_valid   (offer_valid),
    .offer_bank    (offer_bank),
    .offer_count   (offer_count),
    .memory_data   (memory_data),
    .read_activate (read_activate),
    .read_strobe   (read_strobe),
    .offer_taken   (offer_taken),
    .bank_released (bank_released),
    .release_bank  (release_bank),
    .read_address  (read_address),
    .read_ready    (read_ready),
    .read_count    (read_count),
    .read_data     (read_data),
    .starved       (starved)
  );

endmodule

/* hw/ppfifo_bank_drain.sv */
//##########################################################################
// Ping-pong FIFO read stage: takes an offered bank, prefetches word 0 and
// steps through the block on read strobes
//##########################################################################

`timescale 1ns/1ps

module ppfifo_bank_drain
  import ppfifo_bank_pkg::*, ppfifo_data_pkg::*;
(
  input  logic            write_clock,
  input  logic            reset,
  input  logic            offer_valid,
  input  bank_sel_t       offer_bank,
  input  word_count_t     offer_count,
  input  data_t           memory_data,
  input  logic            read_activate,
  input  logic            read_strobe,
  output logic            offer_taken,
  output logic            bank_released,
  output bank_sel_t       release_bank,
  output memory_address_t read_address,
  output logic            read_ready,
  output word_count_t     read_count,
  output data_t           read_data,
  output logic            starved
);

  typedef enum logic [1:0] {
    drain_idle,
    drain_fetch,
    drain_ready,
    drain_active
  } drain_state_t;

  drain_state_t  state;
  bank_sel_t     read_bank;
  bank_address_t read_position;
  bank_address_t next_position;
  word_count_t   words_taken;
  logic          strobe_accepted;

  // Take a block only while the reader is not activated
  assign offer_taken = (state == drain_idle) && offer_valid && !read_activate;

  // Strobes past the end of the block do nothing
  assign strobe_accepted = read_activate && read_strobe &&
                           ((state == drain_ready) || (state == drain_active)) &&
                           (words_taken < read_count);

  // Look one word ahead on a strobe so the next word shows a cycle later
  assign next_position = strobe_accepted ? read_position + 1'b1 : read_position;
  assign read_address  = {read_bank, next_position};

  // Memory output register holds the current word between strobes
  assign read_data = memory_data;

  assign read_ready = (state == drain_ready);

  // Reader let go of the bank
  assign bank_released = (state == drain_active) && !read_activate;
  assign release_bank  = read_bank;

  always_ff @(posedge write_clock) begin
    if (reset) begin
      state         <= drain_idle;
      read_bank     <= 1'b0;
      read_position <= '0;
      words_taken   <= '0;
      read_count    <= '0;
      starved       <= 1'b0;
    end else begin
      // Nothing offered and nobody reading
      starved       <= !read_ready && !read_activate;
      read_position <= next_position;
      if (strobe_accepted) begin
        words_taken <= words_taken + 1'b1;
      end

      case (state)
        drain_idle: begin
          if (offer_taken) begin
            read_bank     <= offer_bank;
            read_count    <= offer_count;
            read_position <= '0;
            words_taken   <= '0;
            state         <= drain_fetch;
          end
        end
        // Word 0 address is on the memory, data lands at this edge
        drain_fetch: begin
          state <= drain_ready;
        end
        drain_ready: begin
          if (read_activate) begin
            state <= drain_active;
          end
        end
        drain_active: begin
          if (!read_activate) begin
            read_count <= '0;
            state      <= drain_idle;
          end
        end
        default: begin
          state <= drain_idle;
        end
      endcase
    end
  end

endmodule

/* hw/ppfifo_bank_fill.sv */
//##########################################################################
// Ping-pong FIFO write stage: bank ownership, word counts and handoff
//##########################################################################

`timescale 1ns/1ps

`include "ppfifo_cfg.svh"

module ppfifo_bank_fill
  import ppfifo_bank_pkg::*, ppfifo_data_pkg::*;
(
  input  logic            write_clock,
  input  logic            reset,
  input  bank_mask_t      write_activate,
  input  logic            write_strobe,
  input  bank_mask_t      bank_done,
  output bank_mask_t      write_ready,
  output bank_mask_t      bank_full,
  output word_count_t     full_count0,
  output word_count_t     full_count1,
  output logic            write_enable,
  output memory_address_t write_address,
  output logic            inactive
);

  localparam word_count_t bank_words = word_count_t'(1 << `PPFIFO_ADDRESS_WIDTH);

  word_count_t   bank_count [2];
  bank_sel_t     fill_bank;
  bank_address_t fill_address;
  logic          bank_has_room;

  // Only activate 10 selects bank 1, anything else writes bank 0
  assign fill_bank = (write_activate == 2'b10);

  // Next free slot is the low bits of the bank's count
  assign fill_address = bank_address_t'(bank_count[fill_bank]);

  // A full bank ignores further strobes
  assign bank_has_room = (bank_count[fill_bank] < bank_words);

  assign write_enable  = (write_activate != 2'b00) && write_strobe && bank_has_room;
  assign write_address = {fill_bank, fill_address};

  assign full_count0 = bank_count[0];
  assign full_count1 = bank_count[1];

  // Nothing stored, nothing owned, nothing arriving
  assign inactive = (bank_count[0] == '0) &&
                    (bank_count[1] == '0) &&
                    (write_ready == 2'b11) &&
                    !write_strobe;

  always_ff @(posedge write_clock) begin
    if (reset) begin
      write_ready   <= 2'b00;
      bank_full     <= 2'b00;
      bank_count[0] <= '0;
      bank_count[1] <= '0;
    end else begin
      // Count each accepted word in the bank being filled
      if (write_enable) begin
        bank_count[fill_bank] <= bank_count[fill_bank] + 1'b1;
      end

      for (int b = 0; b < 2; b++) begin
        // Writer owns the bank once the first word lands
        if (write_enable && (fill_bank == bank_sel_t'(b))) begin
          write_ready[b] <= 1'b0;
        end

        // Idle, empty and handed back by the reader
        if (!write_activate[b] && (bank_count[b] == '0) && bank_done[b]) begin
          write_ready[b] <= 1'b1;
        end

        // Activation dropped with data inside, offer the block
        if (!write_activate[b] && (bank_count[b] != '0)) begin
          bank_full[b] <= 1'b1;
        end

        // Reader captured the block, so the count is no longer needed
        if (!bank_done[b]) begin
          bank_full[b]  <= 1'b0;
          bank_count[b] <= '0;
        end
      end
    end
  end

endmodule

/* hw/ppfifo_bank_memory.sv */
//##########################################################################
// Ping-pong FIFO storage: two banks, one write port, registered read port
//##########################################################################

`timescale 1ns/1ps

`include "ppfifo_cfg.svh"

module ppfifo_bank_memory
  import ppfifo_data_pkg::*;
(
  input  logic            write_clock,
  input  logic            write_enable,
  input  memory_address_t write_address,
  input  data_t           write_data,
  input  memory_address_t read_address,
  output data_t           memory_data
);

  // Both banks side by side, bank select is the top address bit
  localparam int total_words = 2 << `PPFIFO_ADDRESS_WIDTH;

  data_t storage [total_words];

  always_ff @(posedge write_clock) begin
    if (write_enable) begin
      storage[write_address] <= write_data;
    end
    // Data appears one cycle after its address
    memory_data <= storage[read_address];
  end

endmodule

/* hw/ppfifo_bank_pkg.sv */
//##########################################################################
// Ping-pong FIFO bank bookkeeping types
//##########################################################################

`include "ppfifo_cfg.svh"

package ppfifo_bank_pkg;

  // One of the two banks
  typedef logic bank_sel_t;

  // One flag per bank, bit 0 for bank 0
  typedef logic [1:0] bank_mask_t;

  // Words held in a bank
  typedef logic [`PPFIFO_COUNT_WIDTH-1:0] word_count_t;

  // Word position inside one bank
  typedef logic [`PPFIFO_ADDRESS_WIDTH-1:0] bank_address_t;

endpackage

/* hw/ppfifo_cfg.svh */
//##########################################################################
// Ping-pong FIFO configuration: payload, bank address and count widths
//##########################################################################

`ifndef PPFIFO_CFG_SVH
`define PPFIFO_CFG_SVH

// Bits per payload word
`define PPFIFO_DATA_WIDTH 8

// Address bits inside one bank, 16 words deep
`define PPFIFO_ADDRESS_WIDTH 4

// Word counts are wide enough for any block size the host may report
`define PPFIFO_COUNT_WIDTH 24

`endif

/* hw/ppfifo_data_pkg.sv */
//##########################################################################
// Ping-pong FIFO payload and storage address types
//##########################################################################

`include "ppfifo_cfg.svh"

package ppfifo_data_pkg;

  // One payload word
  typedef logic [`PPFIFO_DATA_WIDTH-1:0] data_t;

  // Bank select on top, word position below
  typedef struct packed {
    ppfifo_bank_pkg::bank_sel_t     bank;
    ppfifo_bank_pkg::bank_address_t address;
  } memory_address_t;

endpackage

/* hw/ppfifo_read_arbiter.sv */
//##########################################################################
// Ping-pong FIFO arbiter: captures filled banks and offers one to the
// reader, alternating when both are waiting
//##########################################################################

`timescale 1ns/1ps

module ppfifo_read_arbiter
  import ppfifo_bank_pkg::*;
(
  input  logic        write_clock,
  input  logic        reset,
  input  bank_mask_t  bank_full,
  input  word_count_t full_count0,
  input  word_count_t full_count1,
  input  logic        offer_taken,
  input  logic        bank_released,
  input  bank_sel_t   release_bank,
  output bank_mask_t  bank_done,
  output logic        offer_valid,
  output bank_sel_t   offer_bank,
  output word_count_t offer_count
);

  word_count_t full_count [2];
  word_count_t bank_count [2];
  bank_mask_t  bank_ready;
  bank_mask_t  bank_capture;
  bank_sel_t   next_choice;

  assign full_count[0] = full_count0;
  assign full_count[1] = full_count1;

  // New block from the writer that is not yet owned by the read side
  assign bank_capture = bank_full & bank_done;

  // Some bank is waiting for the reader
  assign offer_valid = (bank_ready != 2'b00);

  always_comb begin
    // Both waiting, take turns
    if (bank_ready == 2'b11) begin
      offer_bank = next_choice;
    end else begin
      // Single waiting bank, bank 1 only if it alone is set
      offer_bank = bank_ready[1];
    end
  end

  assign offer_count = bank_count[offer_bank];

  // Block sizes latched at capture
  always_ff @(posedge write_clock) begin
    for (int b = 0; b < 2; b++) begin
      if (bank_capture[b]) begin
        bank_count[b] <= full_count[b];
      end
    end
  end

  always_ff @(posedge write_clock) begin
    if (reset) begin
      bank_done   <= 2'b11;
      bank_ready  <= 2'b00;
      next_choice <= 1'b0;
    end else begin
      // Reader owns the offered bank now, the other one goes next
      if (offer_taken) begin
        bank_ready[offer_bank] <= 1'b0;
        next_choice            <= ~offer_bank;
      end

      // Lowering done tells the writer the count was taken
      for (int b = 0; b < 2; b++) begin
        if (bank_capture[b]) begin
          bank_ready[b] <= 1'b1;
          bank_done[b]  <= 1'b0;
        end
      end

      // Bank drained, hand it back to the writer
      if (bank_released) begin
        bank_done[release_bank] <= 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the ping-pong FIFO testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module ppfifo_tb -o ppfifo_sim \
  && ./obj_dir/ppfifo_sim | tee sim.log \
  && ! grep -q ">>> FAIL" sim.log \
  && grep -q ">>> PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* tests/ppfifo_input.txt */
// Columns: test code, mode (0 idle, 1 block, 2 ping-pong, 3 starved), bank,
// length in words, expected value (inactive, read_count or starved), all hex
01 00 00 00 01
02 01 00 01 01
03 01 01 05 05
04 00 00 00 01
05 03 00 00 01
06 02 00 08 08
07 00 00 00 01
08 01 00 10 10
09 01 01 14 10
0a 01 00 14 10
0b 02 01 03 03
0c 00 00 00 01
0d 02 00 10 10
0e 01 01 10 10
0f 03 00 00 01
10 02 00 14 10
11 01 00 07 07
12 01 01 02 02
13 02 01 0f 0f
14 00 00 00 01
15 03 00 00 01
16 01 00 0c 0c
17 02 00 01 01
18 00 00 00 01

/* tests/ppfifo_tb.sv */
//##########################################################################
// Ping-pong FIFO testbench: block writes and reads driven from a table
//##########################################################################

`timescale 1ns/1ps

module ppfifo_tb
  import ppfifo_bank_pkg::*, ppfifo_data_pkg::*;
();

  localparam int test_count = 24;
  localparam int bank_depth = 16;
  localparam int wait_limit = 100;

  logic        write_clock = 1'b0;
  logic        reset;
  bank_mask_t  write_activate;
  logic        write_strobe;
  data_t       write_data;
  logic        read_activate;
  logic        read_strobe;
  bank_mask_t  write_ready;
  word_count_t write_fifo_size;
  logic        starved;
  logic        read_ready;
  word_count_t read_count;
  data_t       read_data;
  logic        inactive;

  // Five hex fields per test line
  logic [7:0] test_table [0:test_count*5-1];
  // Words accepted by each bank, in write order
  data_t      written_words [2][$];
  integer     seed;
  string      current_name;
  logic       test_failed;
  int         pass_count;
  int         fail_count;
  int         error_count;

  ppfifo u_ppfifo (
    .write_clock     (write_clock),
    .reset           (reset),
    .write_activate  (write_activate),
    .write_strobe    (write_strobe),
    .write_data      (write_data),
    .read_activate   (read_activate),
    .read_strobe     (read_strobe),
    .write_ready     (write_ready),
    .write_fifo_size (write_fifo_size),
    .starved         (starved),
    .read_ready      (read_ready),
    .read_count      (read_count),
    .read_data       (read_data),
    .inactive        (inactive)
  );

  // 40 ns period
  always #20 write_clock = ~write_clock;

  function automatic string mode_name(input logic [7:0] mode);
    case (mode)
      8'h00: return "idle";
      8'h01: return "block";
      8'h02: return "pingpong";
      8'h03: return "starved";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error: %s %s expected %0h actual %0h", current_name, what, expected, actual);
    error_count++;
    test_failed = 1'b1;
  endtask

  task automatic report_problem(input string what);
    $display("Test %s: %s", current_name, what);
    error_count++;
    test_failed = 1'b1;
  endtask

  // Idle state between blocks, writer owns both banks
  task automatic check_idle(input logic expected_inactive);
    int wait_cycles;
    wait_cycles = 0;
    while ((write_ready !== 2'b11) && (wait_cycles < wait_limit)) begin
      @(negedge write_clock);
      wait_cycles++;
    end
    if (write_ready !== 2'b11) begin
      report_problem("write_ready never returned to both banks while idle");
    end else begin
      if (read_ready !== 1'b0) begin
        report_mismatch("read_ready", 32'd0, 32'(read_ready));
      end
      if (inactive !== expected_inactive) begin
        report_mismatch("inactive", 32'(expected_inactive), 32'(inactive));
      end
      if (write_fifo_size !== word_count_t'(bank_depth)) begin
        report_mismatch("write_fifo_size", 32'(bank_depth), 32'(write_fifo_size));
      end
    end
  endtask

  // Fill one bank, keeping the words a full bank would accept
  task automatic write_block(input bank_sel_t bank, input int length, output logic ok);
    int    wait_cycles;
    data_t word;
    ok = 1'b1;
    wait_cycles = 0;
    while ((write_ready[bank] !== 1'b1) && (wait_cycles < wait_limit)) begin
      @(negedge write_clock);
      wait_cycles++;
    end
    if (write_ready[bank] !== 1'b1) begin
      report_problem($sformatf("bank %0d never became ready for writing", bank));
      ok = 1'b0;
    end else begin
      written_words[bank].delete();
      write_activate = bank ? 2'b10 : 2'b01;
      for (int i = 0; i < length; i++) begin
        word = data_t'($random(seed));
        write_data = word;
        write_strobe = 1'b1;
        // Strobes past the bank depth are dropped by the FIFO
        if (written_words[bank].size() < bank_depth) begin
          written_words[bank].push_back(word);
        end
        @(negedge write_clock);
      end
      write_strobe = 1'b0;
      // Handoff of the block
      write_activate = 2'b00;
      @(negedge write_clock);
    end
  endtask

  // Drain one offered bank and wait until the writer gets it back
  task automatic read_block(input bank_sel_t bank, input word_count_t expected_count,
                            output logic ok);
    int    wait_cycles;
    data_t expected_word;
    ok = 1'b1;
    wait_cycles = 0;
    while ((read_ready !== 1'b1) && (wait_cycles < wait_limit)) begin
      @(negedge write_clock);
      wait_cycles++;
    end
    if (read_ready !== 1'b1) begin
      report_problem($sformatf("read_ready never rose for bank %0d", bank));
      ok = 1'b0;
    end else begin
      if (read_count !== expected_count) begin
        report_mismatch("read_count", 32'(expected_count), 32'(read_count));
      end
      // Word 0 is already out, each strobe brings the next one
      for (int i = 0; i < written_words[bank].size(); i++) begin
        expected_word = written_words[bank][i];
        if (read_data !== expected_word) begin
          report_mismatch($sformatf("word %0d of bank %0d", i, bank),
                          32'(expected_word), 32'(read_data));
        end
        read_activate = 1'b1;
        read_strobe = 1'b1;
        @(negedge write_clock);
      end
      read_strobe = 1'b0;
      if (read_ready !== 1'b0) begin
        report_mismatch("read_ready while reading", 32'd0, 32'(read_ready));
      end
      if (starved !== 1'b0) begin
        report_mismatch("starved while reading", 32'd0, 32'(starved));
      end
      // Release the bank
      read_activate = 1'b0;
      wait_cycles = 0;
      while ((write_ready[bank] !== 1'b1) && (wait_cycles < wait_limit)) begin
        @(negedge write_clock);
        wait_cycles++;
      end
      if (write_ready[bank] !== 1'b1) begin
        report_problem($sformatf("bank %0d was not handed back to the writer", bank));
        ok = 1'b0;
      end
    end
  endtask

  // Starved follows read_ready and read_activate one cycle late
  task automatic check_starved(input logic expected_idle);
    @(negedge write_clock);
    if (read_ready !== 1'b0) begin
      report_problem("a bank was offered during the starved check");
    end
    if (starved !== expected_idle) begin
      report_mismatch("starved while idle", 32'(expected_idle), 32'(starved));
    end
    read_activate = 1'b1;
    @(negedge write_clock);
    if (starved !== 1'b0) begin
      report_mismatch("starved while activated", 32'd0, 32'(starved));
    end
    read_activate = 1'b0;
    @(negedge write_clock);
    if (starved !== expected_idle) begin
      report_mismatch("starved after activation", 32'(expected_idle), 32'(starved));
    end
  endtask

  task automatic run_test(input logic [7:0] code, input logic [7:0] mode,
                          input bank_sel_t bank, input int length,
                          input word_count_t expected);
    logic ok;
    ok = 1'b1;
    test_failed = 1'b0;
    current_name = $sformatf("%s_%02h", mode_name(mode), code);
    case (mode)
      8'h00: begin
        check_idle(expected[0]);
      end
      8'h01: begin
        write_block(bank, length, ok);
        if (ok && (write_ready[bank] !== 1'b0)) begin
          report_mismatch("write_ready of the filled bank", 32'd0, 32'(write_ready[bank]));
        end
        if (ok) begin
          read_block(bank, expected, ok);
        end
      end
      8'h02: begin
        // Both banks filled before any read
        write_block(bank, length, ok);
        if (ok) begin
          write_block(!bank, length, ok);
        end
        if (ok && (write_ready !== 2'b00)) begin
          report_mismatch("write_ready with both banks full", 32'd0, 32'(write_ready));
        end
        if (ok) begin
          read_block(bank, expected, ok);
        end
        if (ok) begin
          read_block(!bank, expected, ok);
        end
      end
      8'h03: begin
        check_starved(expected[0]);
      end
      default: begin
        report_problem("unknown test mode in the input table");
      end
    endcase
    if (test_failed) begin
      fail_count++;
      $display("Test %s failed", current_name);
    end else begin
      pass_count++;
      $display("Test %s passed", current_name);
    end
  endtask

  initial begin
    reset = 1'b1;
    write_activate = 2'b00;
    write_strobe = 1'b0;
    write_data = '0;
    read_activate = 1'b0;
    read_strobe = 1'b0;
    seed = 18168;
    test_failed = 1'b0;
    pass_count = 0;
    fail_count = 0;
    error_count = 0;
    current_name = "";
    $readmemh("tests/ppfifo_input.txt", test_table);

    repeat (3) @(posedge write_clock);
    @(negedge write_clock);
    reset = 1'b0;

    for (int t = 0; t < test_count; t++) begin
      run_test(test_table[5 * t], test_table[5 * t + 1], test_table[5 * t + 2][0],
               int'(test_table[5 * t + 3]), word_count_t'(test_table[5 * t + 4]));
    end

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             test_count, pass_count, fail_count, error_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
